// ==== hdl/vdiv_pkg.sv ====
// Shared widths, encodings and operand word layout of the vector divide unit

package vdiv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    localparam int VDIV_OP_W   = 64;
    localparam int VDIV_BYTES  = VDIV_OP_W / 8;
    localparam int VDIV_LANES  = 8;
    localparam int VDIV_LANE_W = 32;
    localparam int VDIV_ITER   = 32;
    localparam int VDIV_TAG_W  = 4;

    // Byte count 0 to 8 needs one more bit than the byte index
    localparam int VDIV_VL_W   = $clog2(VDIV_BYTES + 1);

    ////////////////////////////////////////////////////////////////////////////
    // Encodings

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } vdiv_eew_e;

    // Bit 0 selects signed, bit 1 selects remainder
    typedef enum logic [1:0] {
        OP_DIVU = 2'b00,
        OP_DIV  = 2'b01,
        OP_REMU = 2'b10,
        OP_REM  = 2'b11
    } vdiv_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Operand word

    // Same 64 bits seen as bytes, halves or words
    typedef union packed {
        logic [VDIV_BYTES-1:0][7:0]  b;
        logic [VDIV_OP_W/16-1:0][15:0] h;
        logic [VDIV_OP_W/32-1:0][31:0] w;
    } vdiv_word_u;

endpackage

// ==== hdl/vdiv_lane.sv ====
// Iterative 32-bit restoring divider lane with RISC-V quotient and remainder rules
`timescale 1ns/1ps

module vdiv_lane (
    input  logic                             clk_i,
    input  logic                             async_rst_ni,
    input  logic                             start_i,
    input  logic                             signed_i,
    input  logic                             rem_i,
    input  logic [vdiv_pkg::VDIV_LANE_W-1:0] dividend_i,
    input  logic [vdiv_pkg::VDIV_LANE_W-1:0] divisor_i,
    output logic                             busy_o,
    output logic                             done_o,
    input  logic                             take_i,
    output logic [vdiv_pkg::VDIV_LANE_W-1:0] res_o
);

    logic                                     run_q;
    logic                                     done_q;
    logic [$clog2(vdiv_pkg::VDIV_ITER+1)-1:0] cnt_q;
    logic                                     last_step;

    logic [vdiv_pkg::VDIV_LANE_W-1:0] quo_q;
    logic [vdiv_pkg::VDIV_LANE_W-1:0] rem_q;
    logic [vdiv_pkg::VDIV_LANE_W-1:0] dvs_q;
    logic [vdiv_pkg::VDIV_LANE_W-1:0] res_q;
    logic                             neg_quo_q;
    logic                             neg_rem_q;
    logic                             zero_q;

    logic                             op1_neg;
    logic                             op2_neg;
    logic [vdiv_pkg::VDIV_LANE_W-1:0] op1_mag;
    logic [vdiv_pkg::VDIV_LANE_W-1:0] op2_mag;
    logic [vdiv_pkg::VDIV_LANE_W+1:0] diff;
    logic [vdiv_pkg::VDIV_LANE_W-1:0] quo_fix;
    logic [vdiv_pkg::VDIV_LANE_W-1:0] rem_fix;

    ////////////////////////////////////////////////////////////////////////////
    // Operand magnitudes

    assign op1_neg = signed_i & dividend_i[vdiv_pkg::VDIV_LANE_W-1];
    assign op2_neg = signed_i & divisor_i[vdiv_pkg::VDIV_LANE_W-1];
    assign op1_mag = op1_neg ? -dividend_i : dividend_i;
    assign op2_mag = op2_neg ? -divisor_i : divisor_i;

    ////////////////////////////////////////////////////////////////////////////
    // Control

    assign last_step = int'(cnt_q) == vdiv_pkg::VDIV_ITER;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            run_q  <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (run_q) begin
            if (last_step) begin
                run_q  <= 1'b0;
                done_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (take_i) begin
            done_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath

    // Borrow in the top bit means the divisor does not fit
    assign diff = {1'b0, rem_q, quo_q[vdiv_pkg::VDIV_LANE_W-1]} - {2'b00, dvs_q};

    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    // Overflow needs no special case, magnitude 2^31 / 1 keeps the dividend
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            quo_q     <= op1_mag;
            rem_q     <= '0;
            dvs_q     <= op2_mag;
            neg_quo_q <= op1_neg ^ op2_neg;
            neg_rem_q <= op1_neg;
            zero_q    <= divisor_i == '0;
        end else if (run_q) begin
            if (last_step) begin
                if (rem_i) begin
                    res_q <= rem_fix;
                end else begin
                    res_q <= zero_q ? '1 : quo_fix;
                end
            end else begin
                quo_q <= {quo_q[vdiv_pkg::VDIV_LANE_W-2:0], ~diff[vdiv_pkg::VDIV_LANE_W+1]};
                if (diff[vdiv_pkg::VDIV_LANE_W+1]) begin
                    rem_q <= {rem_q[vdiv_pkg::VDIV_LANE_W-2:0],
                              quo_q[vdiv_pkg::VDIV_LANE_W-1]};
                end else begin
                    rem_q <= diff[vdiv_pkg::VDIV_LANE_W-1:0];
                end
            end
        end
    end

    assign busy_o = run_q | done_q;
    assign done_o = done_q;
    assign res_o  = res_q;

endmodule

// ==== hdl/vdiv_operand_stage.sv ====
// Operand buffer spreading elements into sign- or zero-extended lane operands
`timescale 1ns/1ps

module vdiv_operand_stage (
    input  logic                                                 clk_i,
    input  logic                                                 async_rst_ni,
    input  logic                                                 in_valid_i,
    output logic                                                 in_ready_o,
    input  logic [vdiv_pkg::VDIV_TAG_W-1:0]                      in_tag_i,
    input  vdiv_pkg::vdiv_op_e                                   in_op_i,
    input  vdiv_pkg::vdiv_eew_e                                  in_eew_i,
    input  logic [vdiv_pkg::VDIV_OP_W-1:0]                       in_op1_i,
    input  logic [vdiv_pkg::VDIV_OP_W-1:0]                       in_op2_i,
    input  logic                                                 in_masked_i,
    input  logic [vdiv_pkg::VDIV_BYTES-1:0]                      in_mask_i,
    input  logic [vdiv_pkg::VDIV_VL_W-1:0]                       in_vl_bytes_i,
    output logic                                                 ex_valid_o,
    input  logic                                                 ex_ready_i,
    output logic [vdiv_pkg::VDIV_TAG_W-1:0]                      ex_tag_o,
    output vdiv_pkg::vdiv_op_e                                   ex_op_o,
    output vdiv_pkg::vdiv_eew_e                                  ex_eew_o,
    output logic [vdiv_pkg::VDIV_BYTES-1:0]                      ex_mask_o,
    output logic [vdiv_pkg::VDIV_LANES*vdiv_pkg::VDIV_LANE_W-1:0] ex_op1_o,
    output logic [vdiv_pkg::VDIV_LANES*vdiv_pkg::VDIV_LANE_W-1:0] ex_op2_o
);

    logic                              valid_q;
    logic [vdiv_pkg::VDIV_TAG_W-1:0]   tag_q;
    vdiv_pkg::vdiv_op_e                op_q;
    vdiv_pkg::vdiv_eew_e               eew_q;
    logic [vdiv_pkg::VDIV_BYTES-1:0]   mask_q;
    vdiv_pkg::vdiv_word_u              op1_q;
    vdiv_pkg::vdiv_word_u              op2_q;
    logic [vdiv_pkg::VDIV_BYTES-1:0]   wr_mask;

    // Places each element in its lane slot, unused lanes get the fill value
    function automatic logic [vdiv_pkg::VDIV_LANES*vdiv_pkg::VDIV_LANE_W-1:0] spread(
        input vdiv_pkg::vdiv_word_u w,
        input logic                 sgn,
        input vdiv_pkg::vdiv_eew_e  eew,
        input logic [31:0]          fill
    );
        logic [vdiv_pkg::VDIV_LANES*vdiv_pkg::VDIV_LANE_W-1:0] lanes;
        lanes = {vdiv_pkg::VDIV_LANES{fill}};
        case (eew)
            vdiv_pkg::EEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    lanes[32*i +: 32] = {{24{sgn & w.b[i][7]}}, w.b[i]};
                end
            end
            vdiv_pkg::EEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    lanes[64*i +: 32] = {{16{sgn & w.h[i][15]}}, w.h[i]};
                end
            end
            default: begin
                for (int i = 0; i < 2; i++) begin
                    lanes[128*i +: 32] = w.w[i];
                end
            end
        endcase
        return lanes;
    endfunction

    // Byte enables from vl, then the optional mask
    always_comb begin
        for (int b = 0; b < vdiv_pkg::VDIV_BYTES; b++) begin
            wr_mask[b] = (b < int'(in_vl_bytes_i)) & (~in_masked_i | in_mask_i[b]);
        end
    end

    assign in_ready_o = ~valid_q | ex_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o & in_valid_i) begin
            tag_q  <= in_tag_i;
            op_q   <= in_op_i;
            eew_q  <= in_eew_i;
            mask_q <= wr_mask;
            op1_q  <= in_op1_i;
            op2_q  <= in_op2_i;
        end
    end

    assign ex_valid_o = valid_q;
    assign ex_tag_o   = tag_q;
    assign ex_op_o    = op_q;
    assign ex_eew_o   = eew_q;
    assign ex_mask_o  = mask_q;

    // Unused lanes divide zero by one
    assign ex_op1_o = spread(op1_q, op_q[0], eew_q, 32'd0);
    assign ex_op2_o = spread(op2_q, op_q[0], eew_q, 32'd1);

endmodule

// ==== hdl/vdiv_result_stage.sv ====
// Output buffer packing lane results back to element width
`timescale 1ns/1ps

module vdiv_result_stage (
    input  logic                                                 clk_i,
    input  logic                                                 async_rst_ni,
    input  logic                                                 lanes_done_i,
    output logic                                                 lanes_take_o,
    input  logic [vdiv_pkg::VDIV_TAG_W-1:0]                      res_tag_i,
    input  vdiv_pkg::vdiv_eew_e                                  res_eew_i,
    input  logic [vdiv_pkg::VDIV_BYTES-1:0]                      res_mask_i,
    input  logic [vdiv_pkg::VDIV_LANES*vdiv_pkg::VDIV_LANE_W-1:0] lane_res_i,
    output logic                                                 out_valid_o,
    input  logic                                                 out_ready_i,
    output logic [vdiv_pkg::VDIV_TAG_W-1:0]                      out_tag_o,
    output logic [vdiv_pkg::VDIV_OP_W-1:0]                       out_res_o,
    output logic [vdiv_pkg::VDIV_BYTES-1:0]                      out_mask_o
);

    logic                            valid_q;
    logic [vdiv_pkg::VDIV_TAG_W-1:0] tag_q;
    logic [vdiv_pkg::VDIV_BYTES-1:0] mask_q;
    vdiv_pkg::vdiv_word_u            word_q;
    vdiv_pkg::vdiv_word_u            packed_w;

    // Low element bits of every used lane
    always_comb begin
        packed_w = '0;
        case (res_eew_i)
            vdiv_pkg::EEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    packed_w.b[i] = lane_res_i[32*i +: 8];
                end
            end
            vdiv_pkg::EEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    packed_w.h[i] = lane_res_i[64*i +: 16];
                end
            end
            default: begin
                for (int i = 0; i < 2; i++) begin
                    packed_w.w[i] = lane_res_i[128*i +: 32];
                end
            end
        endcase
    end

    assign lanes_take_o = lanes_done_i & (~valid_q | out_ready_i);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (lanes_take_o) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lanes_take_o) begin
            tag_q  <= res_tag_i;
            mask_q <= res_mask_i;
            word_q <= packed_w;
        end
    end

    assign out_valid_o = valid_q;
    assign out_tag_o   = tag_q;
    assign out_res_o   = word_q;
    assign out_mask_o  = mask_q;

endmodule

// ==== hdl/vdiv_unit.sv ====
// Element-wise vector integer divide unit with operand, lane and result stages
`timescale 1ns/1ps

module vdiv_unit (
    input  logic                             clk_i,
    input  logic                             async_rst_ni,
    input  logic                             in_valid_i,
    output logic                             in_ready_o,
    input  logic [vdiv_pkg::VDIV_TAG_W-1:0]  in_tag_i,
    input  vdiv_pkg::vdiv_op_e               in_op_i,
    input  vdiv_pkg::vdiv_eew_e              in_eew_i,
    input  logic [vdiv_pkg::VDIV_OP_W-1:0]   in_op1_i,
    input  logic [vdiv_pkg::VDIV_OP_W-1:0]   in_op2_i,
    input  logic                             in_masked_i,
    input  logic [vdiv_pkg::VDIV_BYTES-1:0]  in_mask_i,
    input  logic [vdiv_pkg::VDIV_VL_W-1:0]   in_vl_bytes_i,
    output logic                             out_valid_o,
    input  logic                             out_ready_i,
    output logic [vdiv_pkg::VDIV_TAG_W-1:0]  out_tag_o,
    output logic [vdiv_pkg::VDIV_OP_W-1:0]   out_res_o,
    output logic [vdiv_pkg::VDIV_BYTES-1:0]  out_mask_o
);

    logic                                                 ex_valid;
    logic [vdiv_pkg::VDIV_TAG_W-1:0]                      ex_tag;
    vdiv_pkg::vdiv_op_e                                   ex_op;
    vdiv_pkg::vdiv_eew_e                                  ex_eew;
    logic [vdiv_pkg::VDIV_BYTES-1:0]                      ex_mask;
    logic [vdiv_pkg::VDIV_LANES*vdiv_pkg::VDIV_LANE_W-1:0] ex_op1;
    logic [vdiv_pkg::VDIV_LANES*vdiv_pkg::VDIV_LANE_W-1:0] ex_op2;

    logic                                                 lanes_start;
    logic                                                 lanes_busy;
    logic                                                 lanes_done;
    logic                                                 lanes_take;
    logic [vdiv_pkg::VDIV_LANES-1:0]                      lane_busy;
    logic [vdiv_pkg::VDIV_LANES-1:0]                      lane_done;
    logic [vdiv_pkg::VDIV_LANES*vdiv_pkg::VDIV_LANE_W-1:0] lane_res;

    logic [vdiv_pkg::VDIV_TAG_W-1:0]                      tag_q;
    vdiv_pkg::vdiv_op_e                                   op_q;
    vdiv_pkg::vdiv_eew_e                                  eew_q;
    logic [vdiv_pkg::VDIV_BYTES-1:0]                      mask_q;

    vdiv_operand_stage u_operand_stage (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .in_tag_i      (in_tag_i),
        .in_op_i       (in_op_i),
        .in_eew_i      (in_eew_i),
        .in_op1_i      (in_op1_i),
        .in_op2_i      (in_op2_i),
        .in_masked_i   (in_masked_i),
        .in_mask_i     (in_mask_i),
        .in_vl_bytes_i (in_vl_bytes_i),
        .ex_valid_o    (ex_valid),
        .ex_ready_i    (lanes_start),
        .ex_tag_o      (ex_tag),
        .ex_op_o       (ex_op),
        .ex_eew_o      (ex_eew),
        .ex_mask_o     (ex_mask),
        .ex_op1_o      (ex_op1),
        .ex_op2_o      (ex_op2)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Lanes

    // Restart is allowed in the cycle the previous results are taken
    assign lanes_start = ex_valid & (~lanes_busy | lanes_take);
    assign lanes_busy  = |lane_busy;
    assign lanes_done  = &lane_done;

    // Request fields ride alongside while the lanes work
    always_ff @(posedge clk_i) begin
        if (lanes_start) begin
            tag_q  <= ex_tag;
            op_q   <= ex_op;
            eew_q  <= ex_eew;
            mask_q <= ex_mask;
        end
    end

    for (genvar g = 0; g < vdiv_pkg::VDIV_LANES; g++) begin : g_lane
        vdiv_lane u_lane (
            .clk_i        (clk_i),
            .async_rst_ni (async_rst_ni),
            .start_i      (lanes_start),
            .signed_i     (ex_op[0]),
            .rem_i        (op_q[1]),
            .dividend_i   (ex_op1[vdiv_pkg::VDIV_LANE_W*g +: vdiv_pkg::VDIV_LANE_W]),
            .divisor_i    (ex_op2[vdiv_pkg::VDIV_LANE_W*g +: vdiv_pkg::VDIV_LANE_W]),
            .busy_o       (lane_busy[g]),
            .done_o       (lane_done[g]),
            .take_i       (lanes_take),
            .res_o        (lane_res[vdiv_pkg::VDIV_LANE_W*g +: vdiv_pkg::VDIV_LANE_W])
        );
    end

    vdiv_result_stage u_result_stage (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .lanes_done_i (lanes_done),
        .lanes_take_o (lanes_take),
        .res_tag_i    (tag_q),
        .res_eew_i    (eew_q),
        .res_mask_i   (mask_q),
        .lane_res_i   (lane_res),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_tag_o    (out_tag_o),
        .out_res_o    (out_res_o),
        .out_mask_o   (out_mask_o)
    );

endmodule

// ==== sim/vdiv_unit_assertions.sv ====
// Concurrent checks on the vector divide unit handshakes, reset state and latency
`timescale 1ns/1ps

module vdiv_unit_assertions (
    input logic        clk_i,
    input logic        async_rst_ni,
    input logic        in_valid_i,
    input logic        in_ready_o,
    input logic [3:0]  in_tag_i,
    input logic [1:0]  in_op_i,
    input logic [1:0]  in_eew_i,
    input logic [63:0] in_op1_i,
    input logic [63:0] in_op2_i,
    input logic        in_masked_i,
    input logic [7:0]  in_mask_i,
    input logic [3:0]  in_vl_bytes_i,
    input logic        out_valid_o,
    input logic        out_ready_i,
    input logic [3:0]  out_tag_o,
    input logic [63:0] out_res_o,
    input logic [7:0]  out_mask_o
);

    logic       started_q;
    logic [5:0] since_q;

    // Cycles since the first accepted request, saturating
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            started_q <= 1'b0;
            since_q   <= '0;
        end else if (!started_q) begin
            started_q <= in_valid_i & in_ready_o;
        end else if (since_q != '1) begin
            since_q <= since_q + 6'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable({in_tag_i, in_op_i, in_eew_i,
            in_op1_i, in_op2_i, in_masked_i, in_mask_i, in_vl_bytes_i}))
        else $error("input request dropped or changed before it was accepted");

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable({out_tag_o, out_res_o,
            out_mask_o}))
        else $error("output result dropped or changed before it was taken");

    ////////////////////////////////////////////////////////////////////////////
    // Reset state and latency

    assert property (@(posedge clk_i) $rose(async_rst_ni) |-> !out_valid_o && in_ready_o)
        else $error("wrong handshake state after reset");

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        $rose(out_valid_o) |-> started_q && since_q >= 6'd35)
        else $error("result appeared earlier than the divider latency allows");

endmodule

// ==== sim/vdiv_unit_tb.sv ====
// Testbench driving random divide requests into the vector divide unit against a reference model
`timescale 1ns/1ps

module vdiv_unit_tb;

    localparam int  NUM_REQ    = 200;
    localparam time CLK_PERIOD = 8;

    logic                clk_i;
    logic                async_rst_ni;
    logic                in_valid_i;
    logic                in_ready_o;
    logic [3:0]          in_tag_i;
    vdiv_pkg::vdiv_op_e  in_op_i;
    vdiv_pkg::vdiv_eew_e in_eew_i;
    logic [63:0]         in_op1_i;
    logic [63:0]         in_op2_i;
    logic                in_masked_i;
    logic [7:0]          in_mask_i;
    logic [3:0]          in_vl_bytes_i;
    logic                out_valid_o;
    logic                out_ready_i;
    logic [3:0]          out_tag_o;
    logic [63:0]         out_res_o;
    logic [7:0]          out_mask_o;

    logic [15:0] lfsr = 16'd56952;
    logic [75:0] exp_q[$];
    int          sent = 0;
    int          received = 0;
    logic        full_seen = 1'b0;
    logic        pending = 1'b0;
    time         accept_time;

    vdiv_unit dut (.*);

    bind vdiv_unit vdiv_unit_assertions u_assertions (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    // RISC-V rules per element, truncating division on sign-extended values
    function automatic logic [63:0] ref_result(input logic [1:0] op, input logic [1:0] eew,
                                               input logic [63:0] x, input logic [63:0] y);
        int          ew;
        longint      a;
        longint      b;
        longint      q;
        longint      r;
        logic [63:0] emask;
        logic [63:0] res;
        ew = 8 << eew;
        emask = (64'd1 << ew) - 64'd1;
        res = '0;
        for (int i = 0; i < 64 / ew; i++) begin
            a = longint'((x >> (i * ew)) & emask);
            b = longint'((y >> (i * ew)) & emask);
            if (op[0] && a[ew-1]) a = a - (longint'(1) << ew);
            if (op[0] && b[ew-1]) b = b - (longint'(1) << ew);
            if (b == 0) begin
                q = -1;
                r = a;
            end else if (op[0] && b == -1 && a == -(longint'(1) << (ew - 1))) begin
                q = a;
                r = 0;
            end else begin
                q = a / b;
                r = a % b;
            end
            res |= ((op[1] ? r : q) & emask) << (i * ew);
        end
        return res;
    endfunction

    function automatic logic [7:0] ref_mask(input logic masked, input logic [7:0] m, input int vl);
        logic [7:0] res;
        for (int b = 0; b < 8; b++) begin
            res[b] = (b < vl) && (!masked || m[b]);
        end
        return res;
    endfunction

    // Kind 1 small divisors, 2 divide by zero, 3 most negative by minus one
    task automatic build_request(input int n);
        logic [63:0] r;
        take_bits(2, r);
        in_op_i = vdiv_pkg::vdiv_op_e'(r[1:0]);
        take_bits(2, r);
        in_eew_i = vdiv_pkg::vdiv_eew_e'((r[1:0] == 2'd3) ? 2'd0 : r[1:0]);
        take_bits(64, in_op1_i);
        take_bits(64, in_op2_i);
        take_bits(2, r);
        case (r[1:0])
            2'd1: in_op2_i &= {8{8'h0f}};
            2'd2: in_op2_i = '0;
            2'd3: begin
                in_op2_i = '1;
                case (in_eew_i)
                    vdiv_pkg::EEW_8:  in_op1_i = {8{8'h80}};
                    vdiv_pkg::EEW_16: in_op1_i = {4{16'h8000}};
                    default:          in_op1_i = {2{32'h8000_0000}};
                endcase
            end
            default: ;
        endcase
        take_bits(1, r);
        in_masked_i = r[0];
        take_bits(8, r);
        in_mask_i = r[7:0];
        take_bits(4, r);
        in_vl_bytes_i = r[3:0] % 4'd9;
        in_tag_i = n[3:0];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus, drives at the falling edge and decides the handshake 2 ns later

    initial begin
        logic [63:0] r;
        async_rst_ni = 1'b0;
        in_valid_i = 1'b0;
        in_tag_i = '0;
        in_op_i = vdiv_pkg::OP_DIVU;
        in_eew_i = vdiv_pkg::EEW_8;
        in_op1_i = '0;
        in_op2_i = '0;
        in_masked_i = 1'b0;
        in_mask_i = '0;
        in_vl_bytes_i = '0;
        out_ready_i = 1'b1;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_ni = 1'b1;
        while (sent < NUM_REQ) begin
            @(negedge clk_i);
            // Stalls start once the latency of the first request is measured
            if (received > 0) begin
                take_bits(2, r);
                out_ready_i = r[1:0] != 2'd0;
            end
            if (!pending) begin
                build_request(sent);
                pending = 1'b1;
            end
            in_valid_i = 1'b1;
            #2;
            if (in_ready_o) begin
                exp_q.push_back({in_tag_i, ref_mask(in_masked_i, in_mask_i, int'(in_vl_bytes_i)),
                                 ref_result(in_op_i, in_eew_i, in_op1_i, in_op2_i)});
                if (sent == 0) accept_time = $time + 2;
                sent++;
                pending = 1'b0;
            end else begin
                full_seen = 1'b1;
            end
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
        out_ready_i = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard

    initial begin
        logic [75:0] want;
        @(posedge async_rst_ni);
        while (received < NUM_REQ) begin
            @(negedge clk_i);
            #3;
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) abort_run("Result came out with no request outstanding");
                want = exp_q.pop_front();
                // The valid edge lies 7 ns before this sample point
                if (received == 0) begin
                    check_value("latency", ($time - 7 - accept_time) / CLK_PERIOD, 64'd35);
                end
                check_value("tag", 64'(out_tag_o), 64'(want[75:72]));
                check_value("mask", 64'(out_mask_o), 64'(want[71:64]));
                check_value("result", out_res_o, want[63:0]);
                received++;
            end
        end
        if (!full_seen) begin
            abort_run("in_ready_o never dropped while the pipeline was full");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    initial begin
        #(NUM_REQ * 40 * CLK_PERIOD + 100 * CLK_PERIOD);
        abort_run("Timeout, the watchdog expired before all results came out");
    end

endmodule

// ==== filelist.f ====
hdl/vdiv_pkg.sv
hdl/vdiv_lane.sv
hdl/vdiv_operand_stage.sv
hdl/vdiv_result_stage.sv
hdl/vdiv_unit.sv
sim/vdiv_unit_assertions.sv
sim/vdiv_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the vector divide unit testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module vdiv_unit_tb -o vdiv_sim &&
    ./obj_dir/vdiv_sim | tee /dev/stderr | grep -q "STATUS: PASS" &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
